// ==== Bender.yml ====
package:
  name: flush_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/pipe_pkg.sv
      - rtl/apb_pkg.sv
      - rtl/hazard_unit.sv
      - rtl/redirect_select.sv
      - rtl/flush_status_regs.sv
      - rtl/flush_ctrl_top.sv
  - target: simulation
    files:
      - tb/flush_ctrl_tb.sv

// ==== flist.f ====
+incdir+include
rtl/pipe_pkg.sv
rtl/apb_pkg.sv
rtl/hazard_unit.sv
rtl/redirect_select.sv
rtl/flush_status_regs.sv
rtl/flush_ctrl_top.sv
tb/flush_ctrl_tb.sv

// ==== include/flush_macros.svh ====
`ifndef FLUSH_MACROS_SVH
`define FLUSH_MACROS_SVH

// program counter width, shared by every redirect source
`define FLUSH_PC_W 32

// apb address bus width
`define FLUSH_APB_AW 8

// apb data bus width
`define FLUSH_APB_DW 32

// width of each flush statistics counter
// must stay at or below FLUSH_APB_DW so a counter fits one read
`define FLUSH_CNT_W 16

`endif

// ==== rtl/apb_pkg.sv ====
`include "flush_macros.svh"

package apb_pkg;

    typedef logic [`FLUSH_APB_AW-1:0] apb_addr_t;
    typedef logic [`FLUSH_APB_DW-1:0] apb_data_t;

    // register map of the flush status block
    typedef enum logic [`FLUSH_APB_AW-1:0] {
        reg_last_cause = `FLUSH_APB_AW'h00,
        reg_front_cnt  = `FLUSH_APB_AW'h04,
        reg_back_cnt   = `FLUSH_APB_AW'h08,
        reg_clear      = `FLUSH_APB_AW'h0C
    } flush_reg_e;

endpackage

// ==== rtl/flush_ctrl_top.sv ====
`timescale 1ns/1ps

module flush_ctrl_top (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    flush_from_wb,
    input  logic                    flush_from_ex2,
    input  logic                    flush_from_ex1,
    input  logic                    flush_from_reg,
    input  logic                    flush_from_id,
    input  logic                    flush_from_if1_fifo,
    input  logic                    flush_from_if1,
    input  logic                    flush_by_priv,
    input  pipe_pkg::flush_cause_t  flush_cause_from_wb,
    input  pipe_pkg::flush_cause_t  flush_cause_from_ex1,

    input  pipe_pkg::pc_t           pc_wb,
    input  pipe_pkg::pc_t           pc_priv,
    input  pipe_pkg::pc_t           pc_ex2,
    input  pipe_pkg::pc_t           pc_ex1,
    input  pipe_pkg::pc_t           pc_reg,
    input  pipe_pkg::pc_t           pc_id,
    input  pipe_pkg::pc_t           pc_if1_fifo,
    input  pipe_pkg::pc_t           pc_if1,

    output pipe_pkg::flush_cause_t  flush_cause,
    output logic                    flush_to_ex2_wb,
    output logic                    flush_to_ex1_ex2,
    output logic                    flush_to_reg_ex1,
    output logic                    flush_to_id_reg,
    output logic                    flush_to_fifo_id,
    output logic                    flush_to_fifo,
    output logic                    flush_to_if1_fifo,
    output logic                    flush_to_if0_if1,
    output logic                    flush_to_if0,
    output logic                    flush_to_tlb,
    output logic                    flush_to_icache,
    output logic                    flush_to_dcache,
    output logic                    flush_to_btb,

    output logic                    redirect_valid,
    output pipe_pkg::pc_t           redirect_pc,
    output pipe_pkg::redirect_src_e redirect_src,

    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  apb_pkg::apb_addr_t      paddr,
    input  apb_pkg::apb_data_t      pwdata,
    output apb_pkg::apb_data_t      prdata,
    output logic                    pready,
    output logic                    pslverr
);

    hazard_unit u_hazard_unit (
        .flush_from_wb        (flush_from_wb),
        .flush_from_ex2       (flush_from_ex2),
        .flush_from_ex1       (flush_from_ex1),
        .flush_from_reg       (flush_from_reg),
        .flush_from_id        (flush_from_id),
        .flush_from_if1_fifo  (flush_from_if1_fifo),
        .flush_from_if1       (flush_from_if1),
        .flush_by_priv        (flush_by_priv),
        .flush_cause_from_wb  (flush_cause_from_wb),
        .flush_cause_from_ex1 (flush_cause_from_ex1),
        .flush_cause          (flush_cause),
        .flush_to_ex2_wb      (flush_to_ex2_wb),
        .flush_to_ex1_ex2     (flush_to_ex1_ex2),
        .flush_to_reg_ex1     (flush_to_reg_ex1),
        .flush_to_id_reg      (flush_to_id_reg),
        .flush_to_fifo_id     (flush_to_fifo_id),
        .flush_to_fifo        (flush_to_fifo),
        .flush_to_if1_fifo    (flush_to_if1_fifo),
        .flush_to_if0_if1     (flush_to_if0_if1),
        .flush_to_if0         (flush_to_if0),
        .flush_to_tlb         (flush_to_tlb),
        .flush_to_icache      (flush_to_icache),
        .flush_to_dcache      (flush_to_dcache),
        .flush_to_btb         (flush_to_btb)
    );

    redirect_select u_redirect_select (
        .clk                 (clk),
        .reset               (reset),
        .flush_from_wb       (flush_from_wb),
        .flush_by_priv       (flush_by_priv),
        .flush_from_ex2      (flush_from_ex2),
        .flush_from_ex1      (flush_from_ex1),
        .flush_from_reg      (flush_from_reg),
        .flush_from_id       (flush_from_id),
        .flush_from_if1_fifo (flush_from_if1_fifo),
        .flush_from_if1      (flush_from_if1),
        .pc_wb               (pc_wb),
        .pc_priv             (pc_priv),
        .pc_ex2              (pc_ex2),
        .pc_ex1              (pc_ex1),
        .pc_reg              (pc_reg),
        .pc_id               (pc_id),
        .pc_if1_fifo         (pc_if1_fifo),
        .pc_if1              (pc_if1),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc),
        .redirect_src        (redirect_src)
    );

    // statistics watch the front end restart and the back end kill
    flush_status_regs u_flush_status_regs (
        .clk              (clk),
        .reset            (reset),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .flush_to_if0     (flush_to_if0),
        .flush_to_reg_ex1 (flush_to_reg_ex1),
        .flush_cause      (flush_cause)
    );

endmodule

// ==== rtl/flush_status_regs.sv ====
`timescale 1ns/1ps
`include "flush_macros.svh"

module flush_status_regs (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_pkg::apb_addr_t     paddr,
    input  apb_pkg::apb_data_t     pwdata,
    output apb_pkg::apb_data_t     prdata,
    output logic                   pready,
    output logic                   pslverr,

    input  logic                   flush_to_if0,
    input  logic                   flush_to_reg_ex1,
    input  pipe_pkg::flush_cause_t flush_cause
);

    localparam int PAD_CNT   = `FLUSH_APB_DW - `FLUSH_CNT_W;
    localparam int PAD_CAUSE = `FLUSH_APB_DW - $bits(pipe_pkg::flush_cause_t);

    pipe_pkg::flush_cnt_t   front_cnt;
    pipe_pkg::flush_cnt_t   back_cnt;
    pipe_pkg::flush_cause_t last_cause;

    logic               setup;
    logic               clear_req;
    logic               mapped;
    apb_pkg::apb_data_t rd_mux;

    // no wait states
    assign pready = 1'b1;

    assign setup     = psel & ~penable;
    assign clear_req = psel & penable & pwrite & (paddr == apb_pkg::reg_clear) & pwdata[0];

    always_comb begin
        mapped = 1'b1;
        rd_mux = '0;
        case (paddr)
            apb_pkg::reg_last_cause: rd_mux = {{PAD_CAUSE{1'b0}}, last_cause};
            apb_pkg::reg_front_cnt:  rd_mux = {{PAD_CNT{1'b0}}, front_cnt};
            apb_pkg::reg_back_cnt:   rd_mux = {{PAD_CNT{1'b0}}, back_cnt};
            // clear is write only and reads back as zero
            apb_pkg::reg_clear:      rd_mux = '0;
            default:                 mapped = 1'b0;
        endcase
    end

    // read data and error are sampled in setup, presented in access
    always_ff @(posedge clk) begin
        if (reset) begin
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup & ~mapped;
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            prdata <= rd_mux;
        end
    end

    // counters stick at all ones rather than roll over
    always_ff @(posedge clk) begin
        if (reset || clear_req) begin
            front_cnt  <= '0;
            back_cnt   <= '0;
            last_cause <= pipe_pkg::CAUSE_NONE;
        end else begin
            if (flush_to_if0 && front_cnt != '1) begin
                front_cnt <= front_cnt + 1'b1;
            end
            if (flush_to_reg_ex1 && back_cnt != '1) begin
                back_cnt <= back_cnt + 1'b1;
            end
            if (flush_to_reg_ex1) begin
                last_cause <= flush_cause;
            end
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk) disable iff (reset)
        penable |-> psel
    );

    a_front_no_wrap: assert property (
        @(posedge clk) disable iff (reset)
        !clear_req |=> front_cnt >= $past(front_cnt)
    );

    a_back_no_wrap: assert property (
        @(posedge clk) disable iff (reset)
        !clear_req |=> back_cnt >= $past(back_cnt)
    );

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  logic                 flush_from_wb,
    input  logic                 flush_from_ex2,
    input  logic                 flush_from_ex1,
    input  logic                 flush_from_reg,
    input  logic                 flush_from_id,
    input  logic                 flush_from_if1_fifo,
    input  logic                 flush_from_if1,
    input  logic                 flush_by_priv,

    input  pipe_pkg::flush_cause_t flush_cause_from_wb,
    input  pipe_pkg::flush_cause_t flush_cause_from_ex1,

    output pipe_pkg::flush_cause_t flush_cause,

    output logic                 flush_to_ex2_wb,
    output logic                 flush_to_ex1_ex2,
    output logic                 flush_to_reg_ex1,
    output logic                 flush_to_id_reg,
    output logic                 flush_to_fifo_id,
    output logic                 flush_to_fifo,
    output logic                 flush_to_if1_fifo,
    output logic                 flush_to_if0_if1,
    output logic                 flush_to_if0,
    output logic                 flush_to_tlb,
    output logic                 flush_to_icache,
    output logic                 flush_to_dcache,
    output logic                 flush_to_btb
);

    // wb cause wins over ex1, nothing else reports a cause
    assign flush_cause = flush_from_wb  ? flush_cause_from_wb  :
                         flush_from_ex1 ? flush_cause_from_ex1 :
                                          pipe_pkg::CAUSE_NONE;

    // back end registers, oldest first
    assign flush_to_ex2_wb  = flush_from_wb;

    assign flush_to_ex1_ex2 = flush_from_wb | flush_from_ex2;

    // priv joins here, ex1/ex2 is left alone on a privilege flush
    assign flush_to_reg_ex1 = flush_from_wb | flush_from_ex2 |
                              flush_from_ex1 | flush_by_priv;

    assign flush_to_id_reg  = flush_from_wb | flush_from_ex2 |
                              flush_from_ex1 | flush_by_priv |
                              flush_from_reg;

    // fifo and its output register share one condition
    assign flush_to_fifo_id = flush_from_wb | flush_from_ex2 |
                              flush_from_ex1 | flush_by_priv |
                              flush_from_reg | flush_from_id;

    assign flush_to_fifo    = flush_to_fifo_id;

    // if1 to fifo is only cleared by wb, priv or ex1
    // ex2, reg and id redirects let the fifo input drain
    assign flush_to_if1_fifo = flush_from_wb | flush_by_priv | flush_from_ex1;

    // front end, any request restarts fetch
    assign flush_to_if0_if1 = flush_from_wb | flush_by_priv |
                              flush_from_ex2 | flush_from_ex1 |
                              flush_from_reg | flush_from_id |
                              flush_from_if1_fifo | flush_from_if1;

    assign flush_to_if0     = flush_to_if0_if1;

    // structures track the pipeline register nearest to them
    assign flush_to_tlb     = flush_to_reg_ex1;
    assign flush_to_dcache  = flush_to_reg_ex1;
    assign flush_to_icache  = flush_to_if0_if1;
    assign flush_to_btb     = flush_to_if0_if1;

endmodule

// ==== rtl/pipe_pkg.sv ====
`include "flush_macros.svh"

package pipe_pkg;

    // flush reason code, zero means none or unspecified
    typedef logic [1:0] flush_cause_t;

    parameter flush_cause_t CAUSE_NONE = 2'b00;

    // program counter
    typedef logic [`FLUSH_PC_W-1:0] pc_t;

    // saturating statistics counter
    typedef logic [`FLUSH_CNT_W-1:0] flush_cnt_t;

    // redirect source, listed in priority order
    // wb first, then privilege, then the execute stages and so on up the pipe
    typedef enum logic [2:0] {
        src_wb       = 3'd0,
        src_priv     = 3'd1,
        src_ex2      = 3'd2,
        src_ex1      = 3'd3,
        src_reg      = 3'd4,
        src_id       = 3'd5,
        src_if1_fifo = 3'd6,
        src_if1      = 3'd7
    } redirect_src_e;

endpackage

// ==== rtl/redirect_select.sv ====
`timescale 1ns/1ps

module redirect_select (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    flush_from_wb,
    input  logic                    flush_by_priv,
    input  logic                    flush_from_ex2,
    input  logic                    flush_from_ex1,
    input  logic                    flush_from_reg,
    input  logic                    flush_from_id,
    input  logic                    flush_from_if1_fifo,
    input  logic                    flush_from_if1,

    input  pipe_pkg::pc_t           pc_wb,
    input  pipe_pkg::pc_t           pc_priv,
    input  pipe_pkg::pc_t           pc_ex2,
    input  pipe_pkg::pc_t           pc_ex1,
    input  pipe_pkg::pc_t           pc_reg,
    input  pipe_pkg::pc_t           pc_id,
    input  pipe_pkg::pc_t           pc_if1_fifo,
    input  pipe_pkg::pc_t           pc_if1,

    output logic                    redirect_valid,
    output pipe_pkg::pc_t           redirect_pc,
    output pipe_pkg::redirect_src_e redirect_src
);

    logic                    any_req;
    logic [7:0]              req_vec;
    pipe_pkg::redirect_src_e sel_src;
    pipe_pkg::pc_t           sel_pc;

    // request lines indexed by their redirect source code
    assign req_vec = {flush_from_if1, flush_from_if1_fifo, flush_from_id, flush_from_reg,
                      flush_from_ex1, flush_from_ex2, flush_by_priv, flush_from_wb};

    assign any_req = |req_vec;

    // oldest requester owns the redirect
    always_comb begin
        sel_src = pipe_pkg::src_if1;
        sel_pc  = pc_if1;
        if (flush_from_wb) begin
            sel_src = pipe_pkg::src_wb;
            sel_pc  = pc_wb;
        end else if (flush_by_priv) begin
            sel_src = pipe_pkg::src_priv;
            sel_pc  = pc_priv;
        end else if (flush_from_ex2) begin
            sel_src = pipe_pkg::src_ex2;
            sel_pc  = pc_ex2;
        end else if (flush_from_ex1) begin
            sel_src = pipe_pkg::src_ex1;
            sel_pc  = pc_ex1;
        end else if (flush_from_reg) begin
            sel_src = pipe_pkg::src_reg;
            sel_pc  = pc_reg;
        end else if (flush_from_id) begin
            sel_src = pipe_pkg::src_id;
            sel_pc  = pc_id;
        end else if (flush_from_if1_fifo) begin
            sel_src = pipe_pkg::src_if1_fifo;
            sel_pc  = pc_if1_fifo;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redirect_valid <= 1'b0;
            redirect_src   <= pipe_pkg::src_wb;
        end else begin
            redirect_valid <= any_req;
            redirect_src   <= sel_src;
        end
    end

    // pc only matters while redirect_valid is high
    always_ff @(posedge clk) begin
        redirect_pc <= sel_pc;
    end

    // the source named with a redirect was requesting one cycle earlier
    a_valid_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        redirect_valid |-> (($past(req_vec) >> redirect_src) & 8'h01) != 8'h00
    );

endmodule

// ==== tb/flush_ctrl_tb.sv ====
`timescale 1ns/1ps

module flush_ctrl_tb;

    localparam int N_ENTRIES      = 20;
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 4 + 200;

    // flush vector bit positions, oldest register first
    localparam int B_REG_EX1 = 10;
    localparam int B_IF0     = 4;

    logic clk = 1'b0;
    logic reset;

    logic flush_from_wb;
    logic flush_from_ex2;
    logic flush_from_ex1;
    logic flush_from_reg;
    logic flush_from_id;
    logic flush_from_if1_fifo;
    logic flush_from_if1;
    logic flush_by_priv;
    pipe_pkg::flush_cause_t flush_cause_from_wb;
    pipe_pkg::flush_cause_t flush_cause_from_ex1;

    pipe_pkg::pc_t pc_wb;
    pipe_pkg::pc_t pc_priv;
    pipe_pkg::pc_t pc_ex2;
    pipe_pkg::pc_t pc_ex1;
    pipe_pkg::pc_t pc_reg;
    pipe_pkg::pc_t pc_id;
    pipe_pkg::pc_t pc_if1_fifo;
    pipe_pkg::pc_t pc_if1;

    pipe_pkg::flush_cause_t flush_cause;
    logic flush_to_ex2_wb;
    logic flush_to_ex1_ex2;
    logic flush_to_reg_ex1;
    logic flush_to_id_reg;
    logic flush_to_fifo_id;
    logic flush_to_fifo;
    logic flush_to_if1_fifo;
    logic flush_to_if0_if1;
    logic flush_to_if0;
    logic flush_to_tlb;
    logic flush_to_icache;
    logic flush_to_dcache;
    logic flush_to_btb;

    logic                    redirect_valid;
    pipe_pkg::pc_t           redirect_pc;
    pipe_pkg::redirect_src_e redirect_src;

    logic               psel;
    logic               penable;
    logic               pwrite;
    apb_pkg::apb_addr_t paddr;
    apb_pkg::apb_data_t pwdata;
    apb_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;

    logic [12:0] flush_vec;

    // request bits: wb priv ex2 ex1 reg id if1_fifo if1, msb first
    logic [7:0]              req_tab       [N_ENTRIES];
    pipe_pkg::flush_cause_t  cwb_tab       [N_ENTRIES];
    pipe_pkg::flush_cause_t  cex1_tab      [N_ENTRIES];
    logic [12:0]             exp_flush_tab [N_ENTRIES];
    pipe_pkg::flush_cause_t  exp_cause_tab [N_ENTRIES];
    pipe_pkg::redirect_src_e exp_src_tab   [N_ENTRIES];
    // pcs indexed by redirect source code
    pipe_pkg::pc_t           pc_tab        [N_ENTRIES][8];

    int seed = 32'h782e;
    int cycle_cnt = 0;
    int err_flush = 0;
    int err_cause = 0;
    int err_pc = 0;
    int err_data = 0;
    int err_ctrl = 0;

    flush_ctrl_top dut_i (.*);

    assign flush_vec = {flush_to_ex2_wb, flush_to_ex1_ex2, flush_to_reg_ex1, flush_to_id_reg,
                        flush_to_fifo_id, flush_to_fifo, flush_to_if1_fifo, flush_to_if0_if1,
                        flush_to_if0, flush_to_tlb, flush_to_icache, flush_to_dcache,
                        flush_to_btb};

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("TIMEOUT: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_flush(input string name, input logic [12:0] exp,
                               input logic [12:0] act);
        if (act !== exp) begin
            err_flush = err_flush + 1;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input pipe_pkg::flush_cause_t exp,
                               input pipe_pkg::flush_cause_t act);
        if (act !== exp) begin
            err_cause = err_cause + 1;
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input pipe_pkg::pc_t exp,
                            input pipe_pkg::pc_t act);
        if (act !== exp) begin
            err_pc = err_pc + 1;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input apb_pkg::apb_data_t exp,
                              input apb_pkg::apb_data_t act);
        if (act !== exp) begin
            err_data = err_data + 1;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_src(input string name, input pipe_pkg::redirect_src_e exp,
                             input pipe_pkg::redirect_src_e act);
        if (act !== exp) begin
            err_ctrl = err_ctrl + 1;
            $display("FAILED %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_ctrl = err_ctrl + 1;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic add_entry(input int idx, input logic [7:0] req,
                             input pipe_pkg::flush_cause_t cwb,
                             input pipe_pkg::flush_cause_t cex1,
                             input logic [12:0] exp_flush,
                             input pipe_pkg::flush_cause_t exp_cause,
                             input pipe_pkg::redirect_src_e exp_src);
        int s;
        req_tab[idx]       = req;
        cwb_tab[idx]       = cwb;
        cex1_tab[idx]      = cex1;
        exp_flush_tab[idx] = exp_flush;
        exp_cause_tab[idx] = exp_cause;
        exp_src_tab[idx]   = exp_src;
        for (s = 0; s < 8; s++) begin
            pc_tab[idx][s] = pipe_pkg::pc_t'($random(seed)) & ~32'h3;
        end
    endtask

    task automatic fill_table();
        // single sources, asymmetries of priv and if1_fifo included
        add_entry(0,  8'h80, 2'd2, 2'd1, 13'h1FFF, 2'd2, pipe_pkg::src_wb);
        add_entry(1,  8'h40, 2'd3, 2'd3, 13'h07FF, 2'd0, pipe_pkg::src_priv);
        add_entry(2,  8'h20, 2'd1, 2'd1, 13'h0FBF, 2'd0, pipe_pkg::src_ex2);
        add_entry(3,  8'h10, 2'd1, 2'd3, 13'h07FF, 2'd3, pipe_pkg::src_ex1);
        add_entry(4,  8'h08, 2'd2, 2'd2, 13'h03B5, 2'd0, pipe_pkg::src_reg);
        add_entry(5,  8'h04, 2'd0, 2'd0, 13'h01B5, 2'd0, pipe_pkg::src_id);
        add_entry(6,  8'h02, 2'd1, 2'd2, 13'h0035, 2'd0, pipe_pkg::src_if1_fifo);
        add_entry(7,  8'h01, 2'd3, 2'd1, 13'h0035, 2'd0, pipe_pkg::src_if1);
        add_entry(8,  8'h00, 2'd3, 2'd3, 13'h0000, 2'd0, pipe_pkg::src_wb);
        // combinations, wb cause beats ex1 cause
        add_entry(9,  8'h90, 2'd1, 2'd2, 13'h1FFF, 2'd1, pipe_pkg::src_wb);
        add_entry(10, 8'h30, 2'd3, 2'd2, 13'h0FFF, 2'd2, pipe_pkg::src_ex2);
        add_entry(11, 8'h48, 2'd1, 2'd1, 13'h07FF, 2'd0, pipe_pkg::src_priv);
        add_entry(12, 8'h81, 2'd3, 2'd1, 13'h1FFF, 2'd3, pipe_pkg::src_wb);
        add_entry(13, 8'h06, 2'd2, 2'd2, 13'h01B5, 2'd0, pipe_pkg::src_id);
        add_entry(14, 8'h00, 2'd0, 2'd0, 13'h0000, 2'd0, pipe_pkg::src_wb);
        add_entry(15, 8'h0D, 2'd1, 2'd3, 13'h03B5, 2'd0, pipe_pkg::src_reg);
        add_entry(16, 8'h50, 2'd2, 2'd1, 13'h07FF, 2'd1, pipe_pkg::src_priv);
        add_entry(17, 8'h03, 2'd1, 2'd1, 13'h0035, 2'd0, pipe_pkg::src_if1_fifo);
        add_entry(18, 8'hFF, 2'd2, 2'd1, 13'h1FFF, 2'd2, pipe_pkg::src_wb);
        add_entry(19, 8'h05, 2'd3, 2'd3, 13'h01B5, 2'd0, pipe_pkg::src_id);
    endtask

    task automatic drive_entry(input int i);
        {flush_from_wb, flush_by_priv, flush_from_ex2, flush_from_ex1,
         flush_from_reg, flush_from_id, flush_from_if1_fifo, flush_from_if1} = req_tab[i];
        flush_cause_from_wb  = cwb_tab[i];
        flush_cause_from_ex1 = cex1_tab[i];
        pc_wb       = pc_tab[i][0];
        pc_priv     = pc_tab[i][1];
        pc_ex2      = pc_tab[i][2];
        pc_ex1      = pc_tab[i][3];
        pc_reg      = pc_tab[i][4];
        pc_id       = pc_tab[i][5];
        pc_if1_fifo = pc_tab[i][6];
        pc_if1      = pc_tab[i][7];
    endtask

    task automatic drive_idle();
        {flush_from_wb, flush_by_priv, flush_from_ex2, flush_from_ex1,
         flush_from_reg, flush_from_id, flush_from_if1_fifo, flush_from_if1} = 8'h00;
        flush_cause_from_wb  = '0;
        flush_cause_from_ex1 = '0;
        {pc_wb, pc_priv, pc_ex2, pc_ex1} = '0;
        {pc_reg, pc_id, pc_if1_fifo, pc_if1} = '0;
    endtask

    // runs one negedge after the entry was driven, flush outputs still show it
    task automatic check_entry(input int i);
        string tag;
        tag = $sformatf("entry %0d", i);
        check_flush({tag, " flush"}, exp_flush_tab[i], flush_vec);
        check_cause({tag, " cause"}, exp_cause_tab[i], flush_cause);
        if (req_tab[i] != 8'h00) begin
            check_bit({tag, " redirect_valid"}, 1'b1, redirect_valid);
            check_pc({tag, " redirect_pc"}, pc_tab[i][int'(exp_src_tab[i])], redirect_pc);
            check_src({tag, " redirect_src"}, exp_src_tab[i], redirect_src);
        end else begin
            check_bit({tag, " redirect_valid"}, 1'b0, redirect_valid);
        end
    endtask

    task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        while (!pready) begin
            @(negedge clk);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // no wait states on this slave
        check_bit("apb pready", 1'b1, pready);
        while (!pready) begin
            @(negedge clk);
        end
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input string name, input apb_pkg::apb_addr_t addr,
                               input apb_pkg::apb_data_t exp);
        apb_pkg::apb_data_t data;
        logic               err;
        apb_read(addr, data, err);
        check_data(name, exp, data);
        check_bit({name, " pslverr"}, 1'b0, err);
    endtask

    initial begin
        int                     i;
        int                     exp_front;
        int                     exp_back;
        pipe_pkg::flush_cause_t exp_last;
        apb_pkg::apb_data_t     rd;
        logic                   rd_err;

        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        drive_idle();
        fill_table();

        repeat (8) @(negedge clk);
        reset = 1'b0;

        // one entry per cycle, checked at the following falling edge
        for (i = 0; i < N_ENTRIES; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_entry(i - 1);
            end
            drive_entry(i);
        end
        @(negedge clk);
        check_entry(N_ENTRIES - 1);
        drive_idle();
        @(negedge clk);
        check_bit("idle after table redirect_valid", 1'b0, redirect_valid);

        exp_front = 0;
        exp_back  = 0;
        exp_last  = '0;
        for (i = 0; i < N_ENTRIES; i++) begin
            if (exp_flush_tab[i][B_IF0]) begin
                exp_front = exp_front + 1;
            end
            if (exp_flush_tab[i][B_REG_EX1]) begin
                exp_back = exp_back + 1;
                exp_last = exp_cause_tab[i];
            end
        end

        read_expect("front_cnt", apb_pkg::reg_front_cnt, apb_pkg::apb_data_t'(exp_front));
        read_expect("back_cnt", apb_pkg::reg_back_cnt, apb_pkg::apb_data_t'(exp_back));
        read_expect("last_cause", apb_pkg::reg_last_cause, apb_pkg::apb_data_t'(exp_last));

        apb_write(apb_pkg::reg_clear, 32'h1);
        read_expect("front_cnt after clear", apb_pkg::reg_front_cnt, '0);
        read_expect("back_cnt after clear", apb_pkg::reg_back_cnt, '0);
        read_expect("last_cause after clear", apb_pkg::reg_last_cause, '0);

        // unmapped offset
        apb_read(8'h10, rd, rd_err);
        check_bit("unmapped read pslverr", 1'b1, rd_err);

        $display("errors: flush %0d cause %0d pc %0d data %0d control %0d",
                 err_flush, err_cause, err_pc, err_data, err_ctrl);
        if (err_flush + err_cause + err_pc + err_data + err_ctrl == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
